/* Bender.yml */
package:
  name: axil_fanout

sources:
  - rtl/axil_fanout_pkg.sv
  - rtl/slave_addr_decode.sv
  - rtl/resp_fifo.sv
  - rtl/axil_write_path.sv
  - rtl/axil_read_path.sv
  - rtl/axil_fanout.sv
  - target: verif
    files:
      - verif/axil_fanout_sva.sv
      - verif/axil_fanout_tb.sv

/* compile.f */
rtl/axil_fanout_pkg.sv
rtl/slave_addr_decode.sv
rtl/resp_fifo.sv
rtl/axil_write_path.sv
rtl/axil_read_path.sv
rtl/axil_fanout.sv
verif/axil_fanout_sva.sv
verif/axil_fanout_tb.sv

/* rtl/axil_fanout.sv */
/*
 * AXI4-Lite fan-out bridge, top level
 * Write path and read path side by side
 */
`timescale 1ns/10ps

module axil_fanout
	import axil_fanout_pkg::*;
(
	input  logic                         S_AXI_ACLK,
	input  logic                         S_AXI_ARESETN,
	// Master side
	input  logic                         i_s_awvalid,
	output logic                         o_s_awready,
	input  addr_req_t                    i_s_awreq,
	input  logic                         i_s_wvalid,
	output logic                         o_s_wready,
	input  wr_beat_t                     i_s_wbeat,
	output logic                         o_s_bvalid,
	input  logic                         i_s_bready,
	output resp_t                        o_s_bresp,
	input  logic                         i_s_arvalid,
	output logic                         o_s_arready,
	input  addr_req_t                    i_s_arreq,
	output logic                         o_s_rvalid,
	input  logic                         i_s_rready,
	output rd_beat_t                     o_s_rbeat,
	// Slave side strobes and returns
	output slv_sel_t                     o_m_awvalid,
	output addr_req_t                    o_m_awreq,
	output wr_beat_t                     o_m_wbeat,
	input  resp_t [NUM_SLAVES-1:0]       i_m_bresp,
	output slv_sel_t                     o_m_arvalid,
	output addr_req_t                    o_m_arreq,
	input  rd_beat_t [NUM_SLAVES-1:0]    i_m_rbeat
);

	axil_write_path u_write (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid(i_s_awvalid), .o_awready(o_s_awready), .i_awreq(i_s_awreq),
		.i_wvalid(i_s_wvalid), .o_wready(o_s_wready), .i_wbeat(i_s_wbeat),
		.o_bvalid(o_s_bvalid), .i_bready(i_s_bready), .o_bresp(o_s_bresp),
		.o_m_awvalid(o_m_awvalid), .o_m_awreq(o_m_awreq),
		.o_m_wbeat(o_m_wbeat), .i_m_bresp(i_m_bresp)
	);

	axil_read_path u_read (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_arvalid(i_s_arvalid), .o_arready(o_s_arready), .i_arreq(i_s_arreq),
		.o_rvalid(o_s_rvalid), .i_rready(i_s_rready), .o_rbeat(o_s_rbeat),
		.o_m_arvalid(o_m_arvalid), .o_m_arreq(o_m_arreq),
		.i_m_rbeat(i_m_rbeat)
	);

endmodule

/* rtl/axil_fanout_pkg.sv */
/*
 * Shared definitions for the AXI4-Lite fan-out bridge
 * Widths, slave count, FIFO depth and the slave address table
 * Response codes, request and beat structs, one-hot to index helper
 */
package axil_fanout_pkg;

	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int STRB_W     = DATA_W / 8;
	localparam int NUM_SLAVES = 8;
	localparam int SLV_IDX_W  = 3;
	// Log2 of FIFO depth, also the outstanding request limit
	localparam int FIFO_LG    = 3;

	//////////////////////
	// Slave address table, lowest index wins on overlap
	// 0x2000_0000 to 0x3FFF_FFFF is left unmapped
	localparam logic [ADDR_W-1:0] SLAVE_BASE [0:NUM_SLAVES-1] = '{
		32'h0000_0000, 32'h1000_0000, 32'h4000_0000, 32'h6000_0000,
		32'h8000_0000, 32'hA000_0000, 32'hC000_0000, 32'hE000_0000};
	localparam logic [ADDR_W-1:0] SLAVE_MASK [0:NUM_SLAVES-1] = '{
		32'hF000_0000, 32'hF000_0000, 32'hE000_0000, 32'hE000_0000,
		32'hE000_0000, 32'hE000_0000, 32'hE000_0000, 32'hE000_0000};

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	typedef logic [1:0]            resp_t;
	typedef logic [NUM_SLAVES-1:0] slv_sel_t;

	// Address phase, shared by AW and AR
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [2:0]        prot;
	} addr_req_t;

	// Write data phase
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} wr_beat_t;

	// Read return, per slave and in the R FIFO
	typedef struct packed {
		logic [DATA_W-1:0] data;
		resp_t             resp;
	} rd_beat_t;

	// One-hot select to binary slave index
	function automatic logic [SLV_IDX_W-1:0] sel_to_idx(input slv_sel_t sel);
		logic [SLV_IDX_W-1:0] idx;
		idx = '0;
		for (int k = 0; k < NUM_SLAVES; k++)
		begin
			if (sel[k])
				idx = idx | SLV_IDX_W'(k);
		end
		return idx;
	endfunction

endpackage

/* rtl/axil_read_path.sv */
/*
 * AXI4-Lite read path
 * AR decode and slave read strobe, beat capture with DECERR on a miss
 * Read credit counter and R FIFO
 */
`timescale 1ns/10ps

module axil_read_path
	import axil_fanout_pkg::*;
(
	input  logic                         S_AXI_ACLK,
	input  logic                         S_AXI_ARESETN,
	input  logic                         i_arvalid,
	output logic                         o_arready,
	input  addr_req_t                    i_arreq,
	output logic                         o_rvalid,
	input  logic                         i_rready,
	output rd_beat_t                     o_rbeat,
	output slv_sel_t                     o_m_arvalid,
	output addr_req_t                    o_m_arreq,
	input  rd_beat_t [NUM_SLAVES-1:0]    i_m_rbeat
);

	logic                 ar_fire, r_fire;
	logic                 dcd_valid, dcd_miss;
	logic                 r_pend, r_miss, r_push;
	logic [SLV_IDX_W-1:0] r_idx;
	rd_beat_t             r_beat;
	logic [FIFO_LG:0]     rd_count;
	logic                 rd_full, r_empty;

	assign o_arready = !rd_full;
	assign ar_fire   = i_arvalid && o_arready;
	assign r_fire    = o_rvalid && i_rready;

	//////////////////////
	// Decode stage, never held
	// Its select is the read strobe itself
	slave_addr_decode u_rd_decode (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (ar_fire),
		.i_req        (i_arreq),
		.o_valid      (dcd_valid),
		.o_sel        (o_m_arvalid),
		.o_miss       (dcd_miss),
		.o_req        (o_m_arreq),
		.i_hold       (1'b0)
	);

	//////////////////////
	// Beat capture
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_pend <= 1'b0;
			r_push <= 1'b0;
		end
		else
		begin
			r_pend <= dcd_valid;
			r_push <= r_pend;
		end
	end

	// Remember who was strobed, pick its beat one cycle on
	always_ff @(posedge S_AXI_ACLK)
	begin
		r_idx       <= sel_to_idx(o_m_arvalid);
		r_miss      <= dcd_miss;
		r_beat.data <= i_m_rbeat[r_idx].data;
		r_beat.resp <= r_miss ? RESP_DECERR : i_m_rbeat[r_idx].resp;
	end

	//////////////////////
	// Read credits
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_count <= '0;
		else
		begin
			case ({ar_fire, r_fire})
				2'b10: rd_count <= rd_count + 1'b1;
				2'b01: rd_count <= rd_count - 1'b1;
				default: rd_count <= rd_count;
			endcase
		end
	end

	assign rd_full = rd_count[FIFO_LG];

	resp_fifo #(.WIDTH($bits(rd_beat_t))) u_r_fifo (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr         (r_push),
		.i_data       (r_beat),
		.i_rd         (r_fire),
		.o_data       (o_rbeat),
		.o_empty      (r_empty)
	);

	assign o_rvalid = !r_empty;

endmodule

/* rtl/axil_write_path.sv */
/*
 * AXI4-Lite write path
 * AW decode, W acceptance and slave write strobe
 * BRESP capture with DECERR on a miss, credit counter and B FIFO
 */
`timescale 1ns/10ps

module axil_write_path
	import axil_fanout_pkg::*;
(
	input  logic                         S_AXI_ACLK,
	input  logic                         S_AXI_ARESETN,
	input  logic                         i_awvalid,
	output logic                         o_awready,
	input  addr_req_t                    i_awreq,
	input  logic                         i_wvalid,
	output logic                         o_wready,
	input  wr_beat_t                     i_wbeat,
	output logic                         o_bvalid,
	input  logic                         i_bready,
	output resp_t                        o_bresp,
	output slv_sel_t                     o_m_awvalid,
	output addr_req_t                    o_m_awreq,
	output wr_beat_t                     o_m_wbeat,
	input  resp_t [NUM_SLAVES-1:0]       i_m_bresp
);

	logic                 aw_fire, w_fire, b_fire;
	logic                 dcd_miss;
	slv_sel_t             dcd_sel;
	logic                 b_pend, b_miss, b_push;
	logic [SLV_IDX_W-1:0] b_idx;
	resp_t                b_resp;
	logic [FIFO_LG:0]     wr_count;
	logic                 wr_full, b_empty;

	//////////////////////
	// Address and data acceptance
	// A new AW may enter once the pending W goes, or alongside it
	assign o_awready = (i_wvalid || !o_wready) && !wr_full;
	assign aw_fire   = i_awvalid && o_awready;
	assign w_fire    = i_wvalid && o_wready;
	assign b_fire    = o_bvalid && i_bready;

	// Stage holds until W shows up
	slave_addr_decode u_wr_decode (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid      (aw_fire),
		.i_req        (i_awreq),
		.o_valid      (o_wready),
		.o_sel        (dcd_sel),
		.o_miss       (dcd_miss),
		.o_req        (o_m_awreq),
		.i_hold       (!i_wvalid)
	);

	// Strobe fires in the W transfer cycle only
	assign o_m_awvalid = i_wvalid ? dcd_sel : '0;
	assign o_m_wbeat   = i_wbeat;

	//////////////////////
	// Response capture
	// Slave answers one cycle after its strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			b_pend <= 1'b0;
			b_push <= 1'b0;
		end
		else
		begin
			b_pend <= w_fire;
			b_push <= b_pend;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		b_idx  <= sel_to_idx(dcd_sel);
		b_miss <= dcd_miss;
		b_resp <= b_miss ? RESP_DECERR : i_m_bresp[b_idx];
	end

	//////////////////////
	// Write credits, up on AW and down on B
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_count <= '0;
		else
		begin
			case ({aw_fire, b_fire})
				2'b10: wr_count <= wr_count + 1'b1;
				2'b01: wr_count <= wr_count - 1'b1;
				default: wr_count <= wr_count;
			endcase
		end
	end

	// Full at 2**FIFO_LG outstanding
	assign wr_full = wr_count[FIFO_LG];

	resp_fifo #(.WIDTH($bits(resp_t))) u_b_fifo (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr         (b_push),
		.i_data       (b_resp),
		.i_rd         (b_fire),
		.o_data       (o_bresp),
		.o_empty      (b_empty)
	);

	assign o_bvalid = !b_empty;

endmodule

/* rtl/resp_fifo.sv */
/*
 * Synchronous response FIFO with registered read data
 * Head word is valid whenever the FIFO is not empty
 */
`timescale 1ns/10ps

module resp_fifo
	import axil_fanout_pkg::*;
#(
	parameter int WIDTH = 2
)
(
	input  logic             S_AXI_ACLK,
	input  logic             S_AXI_ARESETN,
	input  logic             i_wr,
	input  logic [WIDTH-1:0] i_data,
	input  logic             i_rd,
	output logic [WIDTH-1:0] o_data,
	output logic             o_empty
);

	logic [WIDTH-1:0] mem [0:(1<<FIFO_LG)-1];
	// Pointers carry one extra wrap bit
	logic [FIFO_LG:0] wr_ptr;
	logic [FIFO_LG:0] rd_ptr;
	logic [FIFO_LG:0] rd_next;
	logic             rd_en;

	assign o_empty = (wr_ptr == rd_ptr);
	// Pops on an empty FIFO are ignored
	assign rd_en   = i_rd && !o_empty;
	assign rd_next = rd_ptr + {{FIFO_LG{1'b0}}, rd_en};

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= wr_ptr + 1'b1;
			rd_ptr <= rd_next;
		end
	end

	// Storage
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
			mem[wr_ptr[FIFO_LG-1:0]] <= i_data;
	end

	//////////////////////
	// Head register
	// When the next head is the word being written, take it straight in
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr && (wr_ptr == rd_next))
			o_data <= i_data;
		else
			o_data <= mem[rd_next[FIFO_LG-1:0]];
	end

endmodule

/* rtl/slave_addr_decode.sv */
/*
 * Registered address decoder
 * One-hot slave select, miss flag and held request
 * Output stays put while held, a new request always loads
 */
`timescale 1ns/10ps

module slave_addr_decode
	import axil_fanout_pkg::*;
(
	input  logic      S_AXI_ACLK,
	input  logic      S_AXI_ARESETN,
	input  logic      i_valid,
	input  addr_req_t i_req,
	output logic      o_valid,
	output slv_sel_t  o_sel,
	output logic      o_miss,
	output addr_req_t o_req,
	input  logic      i_hold
);

	slv_sel_t dec_sel;

	//////////////////////
	// Table match
	// Walk downward so the lowest matching slave is the one left
	always_comb
	begin
		dec_sel = '0;
		for (int k = NUM_SLAVES - 1; k >= 0; k--)
		begin
			if ((i_req.addr & SLAVE_MASK[k]) == SLAVE_BASE[k])
			begin
				dec_sel    = '0;
				dec_sel[k] = 1'b1;
			end
		end
	end

	//////////////////////
	// Decode stage
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_valid <= 1'b0;
			o_sel   <= '0;
			o_miss  <= 1'b0;
		end
		else if (i_valid)
		begin
			o_valid <= 1'b1;
			o_sel   <= dec_sel;
			// Nothing matched, bridge answers with DECERR
			o_miss  <= (dec_sel == '0);
		end
		else if (!i_hold)
		begin
			// Stage drains, select drops with it
			o_valid <= 1'b0;
			o_sel   <= '0;
			o_miss  <= 1'b0;
		end
	end

	// Address and prot ride along
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_valid)
			o_req <= i_req;
	end

endmodule

/* verif/axil_fanout_sva.sv */
/*
 * Assertions on the bridge top-level ports
 * One-hot strobes, write strobe only on a W transfer, quiet responses in reset
 */
`timescale 1ns/10ps

module axil_fanout_sva
	import axil_fanout_pkg::*;
(
	input logic     S_AXI_ACLK,
	input logic     S_AXI_ARESETN,
	input logic     i_wvalid,
	input logic     i_wready,
	input logic     i_bvalid,
	input logic     i_rvalid,
	input slv_sel_t i_aw_strobe,
	input slv_sel_t i_ar_strobe
);

	int fail_count = 0;

	// At most one slave strobed at a time
	a_aw_onehot: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(i_aw_strobe))
		else
		begin
			fail_count++;
			$error("Write strobe selects more than one slave");
		end

	a_ar_onehot: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(i_ar_strobe))
		else
		begin
			fail_count++;
			$error("Read strobe selects more than one slave");
		end

	// Write strobe rides on the W transfer
	a_aw_with_w: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(|i_aw_strobe) |-> (i_wvalid && i_wready))
		else
		begin
			fail_count++;
			$error("Write strobe without a W transfer");
		end

	// FIFOs are empty from the second reset edge on
	a_quiet_reset: assert property (@(posedge S_AXI_ACLK)
		(!S_AXI_ARESETN ##1 !S_AXI_ARESETN) |-> (!i_bvalid && !i_rvalid))
		else
		begin
			fail_count++;
			$error("Response valid while reset is held");
		end

endmodule

bind axil_fanout axil_fanout_sva u_sva (
	.S_AXI_ACLK   (S_AXI_ACLK),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.i_wvalid     (i_s_wvalid),
	.i_wready     (o_s_wready),
	.i_bvalid     (o_s_bvalid),
	.i_rvalid     (o_s_rvalid),
	.i_aw_strobe  (o_m_awvalid),
	.i_ar_strobe  (o_m_arvalid)
);

/* verif/axil_fanout_tb.sv */
/*
 * Testbench for the AXI4-Lite fan-out bridge
 * Clock, reset, eight one-register slave models
 * Directed tests with typed compare tasks and a cycle watchdog
 */
`timescale 1ns/10ps

module axil_fanout_tb
	import axil_fanout_pkg::*;
();

	// Tests need roughly 600 cycles
	localparam int CYCLE_LIMIT = 2000;
	// Longest wait on any single handshake
	localparam int WAIT_LIMIT  = 12;

	logic      S_AXI_ACLK;
	logic      S_AXI_ARESETN;

	// Master side
	logic      s_awvalid;
	logic      s_wvalid;
	logic      s_bready;
	logic      s_arvalid;
	logic      s_rready;
	addr_req_t s_awreq;
	addr_req_t s_arreq;
	wr_beat_t  s_wbeat;
	logic      awready, wready, bvalid, arready, rvalid;
	resp_t     bresp;
	rd_beat_t  rbeat;

	// Slave side
	slv_sel_t                  m_awvalid;
	slv_sel_t                  m_arvalid;
	addr_req_t                 m_awreq;
	addr_req_t                 m_arreq;
	wr_beat_t                  m_wbeat;
	resp_t [NUM_SLAVES-1:0]    m_bresp = '0;
	rd_beat_t [NUM_SLAVES-1:0] m_rbeat = '0;

	logic [DATA_W-1:0] slv_reg [NUM_SLAVES];
	// Expected register contents
	logic [DATA_W-1:0] exp_reg [NUM_SLAVES];

	integer seed;
	int     cycle_count = 0;
	int     errors      = 0;
	int     checks      = 0;
	int     tests       = 0;
	int     err_mark    = 0;

	axil_fanout i_axil_fanout (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_s_awvalid  (s_awvalid),
		.o_s_awready  (awready),
		.i_s_awreq    (s_awreq),
		.i_s_wvalid   (s_wvalid),
		.o_s_wready   (wready),
		.i_s_wbeat    (s_wbeat),
		.o_s_bvalid   (bvalid),
		.i_s_bready   (s_bready),
		.o_s_bresp    (bresp),
		.i_s_arvalid  (s_arvalid),
		.o_s_arready  (arready),
		.i_s_arreq    (s_arreq),
		.o_s_rvalid   (rvalid),
		.i_s_rready   (s_rready),
		.o_s_rbeat    (rbeat),
		.o_m_awvalid  (m_awvalid),
		.o_m_awreq    (m_awreq),
		.o_m_wbeat    (m_wbeat),
		.i_m_bresp    (m_bresp),
		.o_m_arvalid  (m_arvalid),
		.o_m_arreq    (m_arreq),
		.i_m_rbeat    (m_rbeat)
	);

	//////////////////////
	// Address map and slave behavior

	// Slave index hit by an address or -1 for the hole at 0x2000_0000
	function automatic int decode_slave(input logic [ADDR_W-1:0] addr);
		if (addr[31:28] == 4'h0)
			return 0;
		if (addr[31:28] == 4'h1)
			return 1;
		if (addr[31:29] == 3'b001)
			return -1;
		return int'(addr[31:29]);
	endfunction

	function automatic logic [ADDR_W-1:0] base_of(input int k);
		logic [ADDR_W-1:0] a;
		a = k;
		return (k < 2) ? (a << 28) : (a << 29);
	endfunction

	function automatic slv_sel_t sel_for(input int k);
		slv_sel_t s;
		s = '0;
		if (k >= 0)
			s[k] = 1'b1;
		return s;
	endfunction

	// Slave 6 always errors and a miss is answered by the bridge
	function automatic resp_t resp_for(input int k);
		if (k < 0)
			return RESP_DECERR;
		if (k == 6)
			return RESP_SLVERR;
		return RESP_OKAY;
	endfunction

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
		input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] w;
		w = old;
		for (int b = 0; b < STRB_W; b++)
			if (strb[b])
				w[8*b +: 8] = data[8*b +: 8];
		return w;
	endfunction

	function automatic logic [DATA_W-1:0] reset_word(input int k);
		return 32'h5EED_0000 + k * 32'h0000_1111;
	endfunction

	function automatic rd_beat_t expect_beat(input int k);
		rd_beat_t b;
		b.data = (k >= 0) ? exp_reg[k] : '0;
		b.resp = resp_for(k);
		return b;
	endfunction

	// Register slaves answer one cycle after their strobe
	always @(posedge S_AXI_ACLK)
	begin
		for (int k = 0; k < NUM_SLAVES; k++)
		begin
			if (!S_AXI_ARESETN)
			begin
				slv_reg[k] <= reset_word(k);
				m_bresp[k] <= RESP_OKAY;
				m_rbeat[k] <= '0;
			end
			else
			begin
				if (m_awvalid[k])
				begin
					slv_reg[k] <= merge_bytes(slv_reg[k], m_wbeat.data, m_wbeat.strb);
					m_bresp[k] <= resp_for(k);
				end
				if (m_arvalid[k])
					m_rbeat[k] <= {slv_reg[k], resp_for(k)};
			end
		end
	end

	//////////////////////
	// Clock and watchdog
	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#50 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	always @(posedge S_AXI_ACLK)
		cycle_count <= cycle_count + 1;

	initial
	begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
		$display("ERRORS FOUND");
		$finish;
	end

	//////////////////////
	// Checks
	task automatic compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_sel(input string name, input slv_sel_t got, input slv_sel_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_req(input string name, input addr_req_t got, input addr_req_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_resp(input string name, input resp_t got, input resp_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_beat(input string name, input rd_beat_t got, input rd_beat_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_fail(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("%-30s %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	//////////////////////
	// Bus handshakes
	// Every task starts and ends 10 ns after a rising edge
	task automatic step();
		@(posedge S_AXI_ACLK);
		#10;
	endtask

	task automatic send_aw(input logic [ADDR_W-1:0] addr, output addr_req_t req,
		output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		req.addr = addr;
		req.prot = 3'($random(seed));
		s_awvalid = 1'b1;
		s_awreq = req;
		while (!ok && n < WAIT_LIMIT)
		begin
			// Inputs hold until the edge so negedge shows the transfer
			@(negedge S_AXI_ACLK);
			ok = awready;
			step();
			n++;
		end
		s_awvalid = 1'b0;
		// Bridge keeps its own copy of the request
		s_awreq = '0;
	endtask

	task automatic send_w(input wr_beat_t beat, input slv_sel_t exp_sel,
		input addr_req_t exp_req);
		int n;
		bit done;
		n = 0;
		done = 1'b0;
		s_wvalid = 1'b1;
		s_wbeat = beat;
		while (!done && n < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			done = wready;
			// Strobe coincides with the W transfer
			if (done)
			begin
				compare_sel("o_m_awvalid", m_awvalid, exp_sel);
				compare_req("o_m_awreq", m_awreq, exp_req);
			end
			step();
			n++;
		end
		s_wvalid = 1'b0;
		if (!done)
			report_fail("WREADY never rose for a pending write");
	endtask

	task automatic take_b(input resp_t exp);
		int n;
		bit done;
		n = 0;
		done = 1'b0;
		s_bready = 1'b1;
		while (!done && n < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			done = bvalid;
			if (done)
				compare_resp("o_s_bresp", bresp, exp);
			step();
			n++;
		end
		s_bready = 1'b0;
		if (!done)
			report_fail("No write response arrived");
	endtask

	task automatic send_ar(input logic [ADDR_W-1:0] addr, input slv_sel_t exp_sel,
		output bit ok);
		addr_req_t req;
		int n;
		ok = 1'b0;
		n = 0;
		req.addr = addr;
		req.prot = 3'($random(seed));
		s_arvalid = 1'b1;
		s_arreq = req;
		while (!ok && n < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			ok = arready;
			step();
			n++;
		end
		s_arvalid = 0;
		s_arreq = '0;
		if (ok)
		begin
			// Read strobe is the cycle right after AR
			@(negedge S_AXI_ACLK);
			compare_sel("o_m_arvalid", m_arvalid, exp_sel);
			compare_req("o_m_arreq", m_arreq, req);
			step();
		end
	endtask

	task automatic take_r(input rd_beat_t exp, input bit data_known);
		int n;
		bit done;
		n = 0;
		done = 1'b0;
		s_rready = 1'b1;
		while (!done && n < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			done = rvalid;
			if (done && data_known)
				compare_beat("o_s_rbeat", rbeat, exp);
			else if (done)
				compare_resp("o_s_rbeat.resp", rbeat.resp, exp.resp);
			step();
			n++;
		end
		s_rready = 1'b0;
		if (!done)
			report_fail("No read data arrived");
	endtask

	task automatic write_txn(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb);
		wr_beat_t  beat;
		addr_req_t req;
		int        k;
		bit        ok;
		k = decode_slave(addr);
		beat.data = data;
		beat.strb = strb;
		send_aw(addr, req, ok);
		if (!ok)
			report_fail("AWREADY stayed low for a single write");
		else
		begin
			send_w(beat, sel_for(k), req);
			if (k >= 0)
				exp_reg[k] = merge_bytes(exp_reg[k], data, strb);
			take_b(resp_for(k));
		end
	endtask

	task automatic read_txn(input logic [ADDR_W-1:0] addr);
		int k;
		bit ok;
		k = decode_slave(addr);
		send_ar(addr, sel_for(k), ok);
		if (!ok)
			report_fail("ARREADY stayed low for a single read");
		else
			take_r(expect_beat(k), k >= 0);
	endtask

	task automatic check_all_regs();
		for (int k = 0; k < NUM_SLAVES; k++)
			read_txn(base_of(k));
	endtask

	//////////////////////
	// Directed tests
	task automatic reset_values();
		@(negedge S_AXI_ACLK);
		compare_bit("o_s_bvalid", bvalid, 1'b0);
		compare_bit("o_s_rvalid", rvalid, 1'b0);
		compare_bit("o_s_wready", wready, 1'b0);
		compare_bit("o_s_awready", awready, 1'b1);
		compare_bit("o_s_arready", arready, 1'b1);
		compare_sel("o_m_awvalid", m_awvalid, '0);
		compare_sel("o_m_arvalid", m_arvalid, '0);
		step();
		finish_test("reset values");
	endtask

	task automatic all_slaves_rw();
		for (int k = 0; k < NUM_SLAVES; k++)
			write_txn(base_of(k), $random(seed), 4'hF);
		check_all_regs();
		finish_test("write and read every slave");
	endtask

	task automatic partial_strobe();
		write_txn(base_of(3) + 32'h10, $random(seed), 4'b0101);
		read_txn(base_of(3) + 32'h10);
		write_txn(base_of(6) + 32'h4, $random(seed), 4'b1000);
		read_txn(base_of(6) + 32'h4);
		finish_test("partial strobe write");
	endtask

	task automatic unmapped_addr();
		write_txn(32'h2000_0000, 32'hFFFF_FFFF, 4'hF);
		read_txn(32'h2000_0000);
		// Nothing may have leaked into a slave
		check_all_regs();
		finish_test("unmapped address");
	endtask

	task automatic backpressure();
		resp_t             b_exp[$];
		rd_beat_t          r_exp[$];
		wr_beat_t          beat;
		addr_req_t         req;
		logic [ADDR_W-1:0] addr;
		int                taken;
		int                k;
		bit                ok;
		taken = 0;
		for (int i = 0; i < 10; i++)
		begin
			addr = base_of(i % NUM_SLAVES) + 32'(4 * i);
			k = decode_slave(addr);
			send_aw(addr, req, ok);
			if (ok)
			begin
				beat.data = $random(seed);
				beat.strb = 4'hF;
				send_w(beat, sel_for(k), req);
				exp_reg[k] = beat.data;
				b_exp.push_back(resp_for(k));
				taken++;
			end
		end
		if (taken != 8)
			report_fail($sformatf("Write path took %0d of 10 with BREADY low, not 8", taken));
		while (b_exp.size() > 0)
			take_b(b_exp.pop_front());
		for (int i = 8; i < 10; i++)
			write_txn(base_of(i % NUM_SLAVES) + 32'(4 * i), $random(seed), 4'hF);

		// Same again on the read side
		taken = 0;
		for (int i = 0; i < 10; i++)
		begin
			k = (i + 3) % NUM_SLAVES;
			send_ar(base_of(k), sel_for(k), ok);
			if (ok)
			begin
				r_exp.push_back(expect_beat(k));
				taken++;
			end
		end
		if (taken != 8)
			report_fail($sformatf("Read path took %0d of 10 with RREADY low, not 8", taken));
		while (r_exp.size() > 0)
			take_r(r_exp.pop_front(), 1'b1);
		for (int i = 8; i < 10; i++)
			read_txn(base_of((i + 3) % NUM_SLAVES));
		finish_test("back-pressure and credits");
	endtask

	task automatic read_burst();
		rd_beat_t          exp_q[$];
		logic [ADDR_W-1:0] addr;
		int                k;
		int                got;
		int                n;
		s_rready = 1'b1;
		fork
			begin
				// One AR per cycle
				for (int i = 0; i < 16; i++)
				begin
					k = $random(seed) & 7;
					addr = base_of(k) | ($random(seed) & 32'h00FF_FFFC);
					s_arvalid = 1'b1;
					s_arreq.addr = addr;
					s_arreq.prot = 3'b000;
					exp_q.push_back(expect_beat(k));
					@(negedge S_AXI_ACLK);
					if (!arready)
						report_fail("ARREADY dropped during a read burst");
					step();
				end
				s_arvalid = 1'b0;
			end
			begin
				got = 0;
				n = 0;
				while (got < 16 && n < 64)
				begin
					@(negedge S_AXI_ACLK);
					if (rvalid)
					begin
						compare_beat("o_s_rbeat", rbeat, exp_q.pop_front());
						got++;
					end
					n++;
				end
				if (got < 16)
					report_fail("Read burst returned fewer beats than issued");
			end
		join
		step();
		s_rready = 1'b0;
		finish_test("back-to-back reads");
	endtask

	//////////////////////
	// Main sequence
	initial
	begin
		seed = 32'h7dda_2005;
		S_AXI_ARESETN = 1'b0;
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		s_awreq = '0;
		s_arreq = '0;
		s_wbeat = '0;
		for (int k = 0; k < NUM_SLAVES; k++)
			exp_reg[k] = reset_word(k);

		repeat (5) @(posedge S_AXI_ACLK);
		#10;
		S_AXI_ARESETN = 1'b1;

		reset_values();
		all_slaves_rw();
		partial_strobe();
		unmapped_addr();
		backpressure();
		read_burst();

		errors = errors + i_axil_fanout.u_sva.fail_count;
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
